//--- Bender.yml
package:
  name: template_match

sources:
  - verilog/match_pkg.sv
  - verilog/word_ram.sv
  - verilog/match_mem_arbiter.sv
  - verilog/match_controller.sv
  - verilog/window_address_gen.sv
  - verilog/match_engine.sv
  - verilog/template_match_top.sv
  - target: test
    files:
      - bench/tb_template_match.sv

//--- bench/tb_template_match.sv
`timescale 1ns/1ps
`default_nettype none

module tb_template_match
	import match_pkg::*;
();

	localparam int MAX_CYCLES = 20000; // three jobs of ~400 cycles, loads and polls.
	localparam int IMG_WORDS  = IMG_ROWS * IMG_ROW_WORDS;

	typedef struct packed {
		logic  chk;
		addr_t addr;
		word_t data;
	} expect_t;

	typedef struct packed {
		word_t score;
		word_t index;
	} result_t;

	logic     clk = 1'b0;
	logic     rst_n = 1'b0;
	mem_req_t host_req = '0;
	logic     host_ready;
	mem_rsp_t host_rsp;

	word_t   tmpl_m [TMPL_ROWS];   // host-side copy of memory contents.
	word_t   img_m [IMG_WORDS];
	expect_t exp_q [$];            // reads in flight, oldest first.
	word_t   last_rdata = '0;
	int      req_count = 0;
	int      rsp_count = 0;
	int      errors = 0;
	int      checks = 0;
	int      cycles = 0;
	integer  seed = 32'hb636_d6fa;

	template_match_top uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.host_req   (host_req),
		.host_ready (host_ready),
		.host_rsp   (host_rsp)
	);

	always #10 clk = ~clk;

	// byte 0 of the value goes to bits 31:24.
	function automatic word_t to_host_order(input word_t w);
		word_t r;
		for (int k = 0; k < 4; k++) begin
			r[31 - 8*k -: 8] = w[8*k +: 8];
		end
		return r;
	endfunction

	// plain dot product over every window, first maximum wins.
	function automatic result_t best_match();
		int    best;
		int    best_w;
		int    sum;
		word_t iw;
		best   = 0;
		best_w = 0;
		for (int w = 0; w < NUM_WINDOWS; w++) begin
			sum = 0;
			for (int t = 0; t < TMPL_ROWS; t++) begin
				iw = img_m[(w / IMG_ROW_WORDS + t) * IMG_ROW_WORDS + w % IMG_ROW_WORDS];
				for (int k = 0; k < 4; k++) begin
					sum += int'(iw[8*k +: 8]) * int'(tmpl_m[t][8*k +: 8]);
				end
			end
			if (sum > best) begin
				best   = sum;
				best_w = w;
			end
		end
		return '{score: to_host_order(word_t'(best)), index: to_host_order(word_t'(best_w))};
	endfunction

	// leaves the request up, so calls in a row give back-to-back reads.
	task automatic issue_read(input addr_t a, input logic chk, input word_t exp_data);
		@(posedge clk);
		host_req <= '{valid: 1'b1, we: 1'b0, addr: a, wdata: '0};
		@(negedge clk);
		while (!host_ready) @(negedge clk);
		exp_q.push_back('{chk: chk, addr: a, data: exp_data});
		req_count++;
	endtask

	task automatic release_port();
		@(posedge clk);
		host_req <= '0; // this edge takes the last request.
	endtask

	task automatic write_word(input addr_t a, input word_t d);
		@(posedge clk);
		host_req <= '{valid: 1'b1, we: 1'b1, addr: a, wdata: d};
		@(negedge clk);
		while (!host_ready) @(negedge clk);
		release_port();
	endtask

	task automatic read_back_image();
		for (int i = 0; i < IMG_WORDS; i++) begin
			issue_read(IMG_BASE + addr_t'(i), 1'b1, img_m[i]);
		end
		release_port();
	endtask

	// stops on the target code or on the done code.
	task automatic poll_until(input word_t target);
		word_t flag;
		flag = '0;
		while (flag != target && flag != FLAG_DONE) begin
			issue_read(FLAG_ADDR, 1'b0, '0);
			release_port();
			wait (rsp_count == req_count);
			flag = last_rdata;
			checks++;
			assert (flag == FLAG_START || flag == FLAG_ACK || flag == FLAG_DONE) else begin
				errors++;
				$display("Fail at %0t: host_rsp.rdata (flag) = %h, expected %h, %h or %h",
					$time, flag, FLAG_START, FLAG_ACK, FLAG_DONE);
			end
		end
	endtask

	task automatic run_job(input logic zero_img, input logic busy_reads);
		result_t exp_r;
		for (int t = 0; t < TMPL_ROWS; t++) begin
			tmpl_m[t] = word_t'($random(seed));
			write_word(TMPL_BASE + addr_t'(t), tmpl_m[t]);
		end
		for (int i = 0; i < IMG_WORDS; i++) begin
			img_m[i] = zero_img ? '0 : word_t'($random(seed));
			write_word(IMG_BASE + addr_t'(i), img_m[i]);
		end
		for (int t = 0; t < TMPL_ROWS; t++) begin
			issue_read(TMPL_BASE + addr_t'(t), 1'b1, tmpl_m[t]);
		end
		release_port();
		read_back_image();
		write_word(FLAG_ADDR, FLAG_START);
		if (busy_reads) begin
			poll_until(FLAG_ACK);
			read_back_image(); // host holds the port while the engine runs.
			read_back_image();
		end
		poll_until(FLAG_DONE);
		exp_r = best_match();
		issue_read(RES_SCORE_ADDR, 1'b1, exp_r.score);
		issue_read(RES_INDEX_ADDR, 1'b1, exp_r.index);
		release_port();
		wait (rsp_count == req_count);
	endtask

	// compares every host read response with the queued expectation.
	always @(negedge clk) begin : check_responses
		expect_t e;
		if (rst_n && host_rsp.rvalid) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("Error at %0t: read response with no read outstanding", $time);
			end else begin
				e = exp_q.pop_front();
				if (e.chk) begin
					checks++;
					assert (host_rsp.rdata == e.data) else begin
						errors++;
						$display("Fail at %0t: host_rsp.rdata (addr %0d) = %h, expected %h",
							$time, e.addr, host_rsp.rdata, e.data);
					end
				end
			end
			last_rdata = host_rsp.rdata;
			rsp_count++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Error: run did not finish within %0d cycles", MAX_CYCLES);
			$display("errors: %0d, checks: %0d", errors + 1, checks);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		run_job(1'b0, 1'b0);
		run_job(1'b1, 1'b0);  // zero image, every window ties at 0.
		run_job(1'b0, 1'b1);
		repeat (4) @(posedge clk);
		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
verilog/match_pkg.sv
verilog/word_ram.sv
verilog/match_mem_arbiter.sv
verilog/match_controller.sv
verilog/window_address_gen.sv
verilog/match_engine.sv
verilog/template_match_top.sv
bench/tb_template_match.sv

//--- verilog/match_controller.sv
`timescale 1ns/1ps
`default_nettype none

module match_controller
	import match_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	output mem_req_t req,
	input  logic     ready,
	input  mem_rsp_t rsp,
	output logic     eng_start,
	input  logic     eng_done
);

	typedef enum logic [2:0] {POLL, CHECK, ACK, RUN, POST} ctrl_state_t;

	ctrl_state_t state, next_state;

	always_comb begin
		next_state = state;
		case (state)
			POLL: if (ready) next_state = CHECK;       // flag read accepted.
			CHECK: begin
				if (rsp.rvalid) begin
					next_state = (rsp.rdata == FLAG_START) ? ACK : POLL;
				end
			end
			ACK: if (ready) next_state = RUN;
			RUN: if (eng_done) next_state = POST;
			POST: if (ready) next_state = POLL;        // back to polling.
			default: next_state = POLL;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= POLL;
		end else begin
			state <= next_state;
		end
	end

	// all traffic goes to the flag word.
	always_comb begin
		req      = '0;
		req.addr = FLAG_ADDR;
		case (state)
			POLL: req.valid = 1'b1;
			ACK: begin
				req.valid = 1'b1;
				req.we    = 1'b1;
				req.wdata = FLAG_ACK;
			end
			POST: begin
				req.valid = 1'b1;
				req.we    = 1'b1;
				req.wdata = FLAG_DONE;
			end
			default: ;
		endcase
	end

	// engine starts with the accepted ack write.
	assign eng_start = (state == ACK) && ready;

	// flag data and the done pulse only come while awaited.
	a_awaited: assert property (@(posedge clk) disable iff (!rst_n)
		(!rsp.rvalid || state == CHECK) && (!eng_done || state == RUN));

endmodule

`default_nettype wire

//--- verilog/match_engine.sv
`timescale 1ns/1ps
`default_nettype none

module match_engine
	import match_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     start,
	output logic     done,
	output mem_req_t req,
	input  logic     ready,
	input  mem_rsp_t rsp
);

	typedef enum logic [2:0] {
		IDLE, LOAD_TMPL, SCAN, WRITE_SCORE, WRITE_INDEX, FINISH
	} eng_state_t;

	eng_state_t state;
	logic [6:0] req_cnt;        // words requested in this phase.
	logic [6:0] rsp_cnt;        // words received in this phase.
	word_t      tmpl_q [TMPL_ROWS];
	score_t     acc, win_score, best_score;
	win_idx_t   best_idx, rsp_win;
	logic [1:0] rsp_row;
	addr_t      img_addr, tmpl_addr;

	// host byte order, internal byte 0 lands in bits 31:24.
	function automatic word_t swap_bytes(word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic logic [17:0] row_dot(word_t img, word_t tmpl);
		logic [17:0] sum;
		pixel_t      p, t;
		sum = '0;
		for (int k = 0; k < $bits(word_t) / $bits(pixel_t); k++) begin
			p   = img[8*k +: 8];
			t   = tmpl[8*k +: 8];
			sum = sum + 18'(p) * 18'(t);
		end
		return sum;
	endfunction

	window_address_gen u_addr (
		.win       (win_idx_t'(req_cnt[6:2])),
		.tmpl_row  (req_cnt[1:0]),
		.img_addr  (img_addr),
		.tmpl_addr (tmpl_addr)
	);

	assign rsp_row   = rsp_cnt[1:0];
	assign rsp_win   = win_idx_t'(rsp_cnt[6:2]);
	assign win_score = acc + score_t'(row_dot(rsp.rdata, tmpl_q[rsp_row]));

	always_comb begin
		req = '0;
		case (state)
			LOAD_TMPL: begin
				req.valid = req_cnt < 7'(TMPL_ROWS);
				req.addr  = tmpl_addr;
			end
			SCAN: begin
				req.valid = req_cnt < 7'(NUM_WINDOWS * TMPL_ROWS);
				req.addr  = img_addr;
			end
			WRITE_SCORE: begin
				req.valid = 1'b1;
				req.we    = 1'b1;
				req.addr  = RES_SCORE_ADDR;
				req.wdata = swap_bytes(word_t'(best_score));
			end
			WRITE_INDEX: begin
				req.valid = 1'b1;
				req.we    = 1'b1;
				req.addr  = RES_INDEX_ADDR;
				req.wdata = swap_bytes(word_t'(best_idx));
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (state == LOAD_TMPL && rsp.rvalid) tmpl_q[rsp_row] <= rsp.rdata;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= IDLE;
			req_cnt    <= '0;
			rsp_cnt    <= '0;
			acc        <= '0;
			best_score <= '0;
			best_idx   <= '0;
		end else begin
			if (req.valid && ready) req_cnt <= req_cnt + 7'd1;
			if (rsp.rvalid) rsp_cnt <= rsp_cnt + 7'd1;
			case (state)
				IDLE: begin
					if (start) begin
						state      <= LOAD_TMPL;
						req_cnt    <= '0;
						rsp_cnt    <= '0;
						acc        <= '0;
						best_score <= '0;
						best_idx   <= '0;
					end
				end
				LOAD_TMPL: begin
					if (rsp.rvalid && rsp_cnt == 7'(TMPL_ROWS - 1)) begin
						state   <= SCAN;
						req_cnt <= '0;
						rsp_cnt <= '0;
					end
				end
				SCAN: begin
					if (rsp.rvalid) begin
						if (rsp_row == 2'(TMPL_ROWS - 1)) begin
							acc <= '0;           // window complete.
							if (win_score > best_score) begin
								best_score <= win_score; // ties keep lower index.
								best_idx   <= rsp_win;
							end
						end else begin
							acc <= win_score;
						end
						if (rsp_cnt == 7'(NUM_WINDOWS * TMPL_ROWS - 1)) state <= WRITE_SCORE;
					end
				end
				WRITE_SCORE: if (ready) state <= WRITE_INDEX;
				WRITE_INDEX: if (ready) state <= FINISH;
				FINISH: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	assign done = (state == FINISH);

	// every response answers a read still owed in this run.
	a_rsp_owed: assert property (@(posedge clk) disable iff (!rst_n)
		rsp.rvalid |-> (state == LOAD_TMPL || state == SCAN) && rsp_cnt < req_cnt);

endmodule

`default_nettype wire

//--- verilog/match_mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module match_mem_arbiter
	import match_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  mem_req_t host_req,
	input  mem_req_t ctrl_req,
	input  mem_req_t eng_req,
	output logic     host_ready,
	output logic     ctrl_ready,
	output logic     eng_ready,
	output mem_rsp_t host_rsp,
	output mem_rsp_t ctrl_rsp,
	output mem_rsp_t eng_rsp
);

	mem_req_t   grant_req;
	logic [2:0] rd_pend;   // owner of the read in flight, one-hot.
	word_t      ram_rdata;

	// fixed priority, host first.
	always_comb begin
		host_ready = 1'b0;
		ctrl_ready = 1'b0;
		eng_ready  = 1'b0;
		grant_req  = '0;
		if (host_req.valid) begin
			host_ready = 1'b1;
			grant_req  = host_req;
		end else if (ctrl_req.valid) begin
			ctrl_ready = 1'b1;
			grant_req  = ctrl_req;
		end else if (eng_req.valid) begin
			eng_ready = 1'b1;
			grant_req = eng_req;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_pend <= '0;
		end else begin
			rd_pend <= {eng_ready, ctrl_ready, host_ready} & {3{~grant_req.we}};
		end
	end

	word_ram u_ram (
		.clk   (clk),
		.rst_n (rst_n),
		.addr  (grant_req.addr),
		.we    (grant_req.valid & grant_req.we),
		.wdata (grant_req.wdata),
		.rdata (ram_rdata)
	);

	// data goes to everyone, rvalid only to the owner.
	assign host_rsp = '{rvalid: rd_pend[0], rdata: ram_rdata};
	assign ctrl_rsp = '{rvalid: rd_pend[1], rdata: ram_rdata};
	assign eng_rsp  = '{rvalid: rd_pend[2], rdata: ram_rdata};

	// a requester that waits keeps its request.
	a_ctrl_held: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl_req.valid && !ctrl_ready |=> $stable(ctrl_req));
	a_eng_held: assert property (@(posedge clk) disable iff (!rst_n)
		eng_req.valid && !eng_ready |=> $stable(eng_req));

endmodule

`default_nettype wire

//--- verilog/match_pkg.sv
`default_nettype none

package match_pkg;

	typedef logic [7:0]  addr_t;    // word address, 256 words.
	typedef logic [31:0] word_t;
	typedef logic [7:0]  pixel_t;
	typedef logic [19:0] score_t;   // 16 products of 8x8 bits.
	typedef logic [4:0]  win_idx_t;

	// memory map.
	localparam addr_t FLAG_ADDR      = 8'd0;
	localparam addr_t RES_SCORE_ADDR = 8'd1;
	localparam addr_t RES_INDEX_ADDR = 8'd2;
	localparam addr_t TMPL_BASE      = 8'd16; // one word per template row.
	localparam addr_t IMG_BASE       = 8'd32; // four words per image row.

	localparam int TMPL_ROWS     = 4;
	localparam int IMG_ROW_WORDS = 4;
	localparam int IMG_ROWS      = 8;
	localparam int WIN_ROWS      = IMG_ROWS - TMPL_ROWS + 1;
	localparam int NUM_WINDOWS   = WIN_ROWS * IMG_ROW_WORDS;

	// flag word codes.
	localparam word_t FLAG_START = 32'h0001_0000;
	localparam word_t FLAG_ACK   = 32'h0000_0002;
	localparam word_t FLAG_DONE  = 32'h0000_0004;

	typedef struct packed {
		logic  valid;
		logic  we;
		addr_t addr;
		word_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic  rvalid;
		word_t rdata;
	} mem_rsp_t;

endpackage

`default_nettype wire

//--- verilog/template_match_top.sv
`timescale 1ns/1ps
`default_nettype none

module template_match_top
	import match_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  mem_req_t host_req,
	output logic     host_ready,
	output mem_rsp_t host_rsp
);

	mem_req_t ctrl_req, eng_req;
	mem_rsp_t ctrl_rsp, eng_rsp;
	logic     ctrl_ready, eng_ready;
	logic     eng_start, eng_done;

	match_mem_arbiter u_arbiter (
		.clk        (clk),
		.rst_n      (rst_n),
		.host_req   (host_req),
		.ctrl_req   (ctrl_req),
		.eng_req    (eng_req),
		.host_ready (host_ready),
		.ctrl_ready (ctrl_ready),
		.eng_ready  (eng_ready),
		.host_rsp   (host_rsp),
		.ctrl_rsp   (ctrl_rsp),
		.eng_rsp    (eng_rsp)
	);

	match_controller u_controller (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (ctrl_req),
		.ready     (ctrl_ready),
		.rsp       (ctrl_rsp),
		.eng_start (eng_start),
		.eng_done  (eng_done)
	);

	match_engine u_engine (
		.clk   (clk),
		.rst_n (rst_n),
		.start (eng_start),
		.done  (eng_done),
		.req   (eng_req),
		.ready (eng_ready),
		.rsp   (eng_rsp)
	);

endmodule

`default_nettype wire

//--- verilog/window_address_gen.sv
`timescale 1ns/1ps
`default_nettype none

module window_address_gen
	import match_pkg::*;
(
	input  win_idx_t   win,
	input  logic [1:0] tmpl_row,
	output addr_t      img_addr,
	output addr_t      tmpl_addr
);

	logic [$clog2(WIN_ROWS)-1:0]      win_row;
	logic [$clog2(IMG_ROW_WORDS)-1:0] win_col;
	logic [$clog2(IMG_ROWS)-1:0]      img_row;

	// window w sits at row w/4, word column w%4.
	assign win_row = ($clog2(WIN_ROWS))'(win / IMG_ROW_WORDS);
	assign win_col = ($clog2(IMG_ROW_WORDS))'(win % IMG_ROW_WORDS);

	assign img_row = ($clog2(IMG_ROWS))'(win_row) + ($clog2(IMG_ROWS))'(tmpl_row);

	assign img_addr = IMG_BASE
		+ addr_t'(img_row * IMG_ROW_WORDS)
		+ addr_t'(win_col);

	assign tmpl_addr = TMPL_BASE + addr_t'(tmpl_row); // one word per row.

endmodule

`default_nettype wire

//--- verilog/word_ram.sv
`timescale 1ns/1ps
`default_nettype none

module word_ram
	import match_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  addr_t addr,
	input  logic  we,
	input  word_t wdata,
	output word_t rdata
);

	word_t mem [256];

	// only the flag word needs a known value after reset.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem[FLAG_ADDR] <= '0;
		end else if (we) begin
			mem[addr] <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		rdata <= mem[addr]; // one cycle read latency.
	end

endmodule

`default_nettype wire
